/* hw/radio_settings.svh */
`ifndef RADIO_SETTINGS_SVH
`define RADIO_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Setting bus addresses
////////////////////////////////////////////////////////////////////////////

`define SR_LOOPBACK        8'd6
`define SR_TEST            8'd21
`define SR_CODEC_IDLE      8'd22
`define SR_READBACK        8'd32

// Packet length, then stream id, then overflow clear
`define SR_RX_CTRL         8'd96

// Time high word, then low word, then time control
`define SR_TIME            8'd128

////////////////////////////////////////////////////////////////////////////
// Reset values and sizes
////////////////////////////////////////////////////////////////////////////

// Payload beats per packet
`define RX_PKT_LEN_DEFAULT 8'd4

// Log2 of the sample FIFO depth
`define SAMPLE_FIFO_SIZE   5

`endif

/* hw/radio_pkg.sv */
package radio_pkg;

   // Setting bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // IQ sample with I in the upper half
   typedef logic [31:0] sample_t;

   typedef logic [63:0] vita_time_t;

   // Readback
   typedef logic [2:0]  rb_addr_t;
   typedef logic [63:0] rb_data_t;

   // RX packet stream
   typedef logic [63:0] chdr_word_t;
   typedef logic [7:0]  pkt_len_t;
   typedef logic [15:0] seqnum_t;

   typedef enum logic [1:0] {
      IDLE,
      HEADER,
      PAYLOAD
   } framer_state_t;

endpackage

/* hw/radio_timekeeper.sv */
`include "radio_settings.svh"

module radio_timekeeper (
   input  logic                  radio_clk,
   input  logic                  radio_rst,
   input  logic                  i_set_stb,
   input  radio_pkg::set_addr_t  i_set_addr,
   input  radio_pkg::set_data_t  i_set_data,
   input  logic                  i_pps,
   output radio_pkg::vita_time_t o_vita_time,
   output radio_pkg::vita_time_t o_time_lastpps
);
   import radio_pkg::*;

   set_data_t time_hi;
   set_data_t time_lo;
   logic      load_armed;
   logic      pps_d;
   logic      pps_edge;
   logic      ctrl_wr;

   assign ctrl_wr = i_set_stb && (i_set_addr == (`SR_TIME + 8'd2));

   // Pending load value
   always_ff @(posedge radio_clk) begin
      if (i_set_stb && (i_set_addr == `SR_TIME))
         time_hi <= i_set_data;
      if (i_set_stb && (i_set_addr == (`SR_TIME + 8'd1)))
         time_lo <= i_set_data;
   end

   // Rising edge of PPS, one stage after the pin
   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         pps_d    <= 1'b0;
         pps_edge <= 1'b0;
      end else begin
         pps_d    <= i_pps;
         pps_edge <= i_pps & ~pps_d;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_vita_time    <= '0;
         o_time_lastpps <= '0;
         load_armed     <= 1'b0;
      end else begin
         if (pps_edge)
            o_time_lastpps <= o_vita_time;
         if (ctrl_wr && i_set_data[0]) begin
            o_vita_time <= {time_hi, time_lo};
            load_armed  <= 1'b0;
         end else if (load_armed && pps_edge) begin
            o_vita_time <= {time_hi, time_lo};
            load_armed  <= 1'b0;
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end
         // Bit 0 clear waits for the next PPS
         if (ctrl_wr && !i_set_data[0])
            load_armed <= 1'b1;
      end
   end

endmodule

/* hw/radio_settings_regs.sv */
`include "radio_settings.svh"

module radio_settings_regs (
   input  logic                     radio_clk,
   input  logic                     radio_rst,
   input  logic                     i_set_stb,
   input  radio_pkg::set_addr_t     i_set_addr,
   input  radio_pkg::set_data_t     i_set_data,
   input  radio_pkg::vita_time_t    i_vita_time,
   input  radio_pkg::vita_time_t    i_time_lastpps,
   input  radio_pkg::sample_t       i_tx,
   input  radio_pkg::sample_t       i_rx,
   input  logic                     i_overflow,
   input  radio_pkg::framer_state_t i_framer_state,
   output logic                     o_loopback,
   output radio_pkg::sample_t       o_codec_idle,
   output radio_pkg::pkt_len_t      o_rx_pkt_len,
   output radio_pkg::set_data_t     o_rx_sid,
   output radio_pkg::rb_data_t      o_rb_data
);
   import radio_pkg::*;

   set_data_t test_reg;
   rb_addr_t  rb_addr;
   logic      overflow_flag;
   logic      ovf_clear;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_loopback   <= 1'b0;
         test_reg     <= '0;
         o_codec_idle <= '0;
         rb_addr      <= '0;
         o_rx_pkt_len <= `RX_PKT_LEN_DEFAULT;
         o_rx_sid     <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_LOOPBACK:           o_loopback   <= i_set_data[0];
            `SR_TEST:               test_reg     <= i_set_data;
            `SR_CODEC_IDLE:         o_codec_idle <= i_set_data;
            `SR_READBACK:           rb_addr      <= i_set_data[2:0];
            `SR_RX_CTRL:            o_rx_pkt_len <= i_set_data[7:0];
            (`SR_RX_CTRL + 8'd1):   o_rx_sid     <= i_set_data;
            default: ;
         endcase
      end
   end

   // Sticky overflow, set beats clear
   assign ovf_clear = i_set_stb && (i_set_addr == (`SR_RX_CTRL + 8'd2));

   always_ff @(posedge radio_clk) begin
      if (radio_rst)
         overflow_flag <= 1'b0;
      else if (i_overflow)
         overflow_flag <= 1'b1;
      else if (ovf_clear)
         overflow_flag <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (rb_addr)
         3'd0:    o_rb_data = {32'd0, test_reg};
         3'd1:    o_rb_data = i_vita_time;
         3'd2:    o_rb_data = i_time_lastpps;
         3'd3:    o_rb_data = {i_tx, i_rx};
         3'd4:    o_rb_data = {61'd0, overflow_flag, i_framer_state};
         default: o_rb_data = '0;
      endcase
   end

endmodule

/* hw/radio_frontend.sv */
module radio_frontend (
   input  logic               radio_clk,
   input  logic               radio_rst,
   input  logic               i_loopback,
   input  radio_pkg::sample_t i_codec_idle,
   input  radio_pkg::sample_t i_tx_sample,
   input  logic               i_run_tx,
   input  radio_pkg::sample_t i_rx,
   input  logic               i_run_rx,
   output radio_pkg::sample_t o_tx,
   output radio_pkg::sample_t o_rx_sample,
   output logic               o_rx_push
);
   import radio_pkg::*;

   sample_t rx_word;

   // TX word, idle pattern when not running
   always_ff @(posedge radio_clk) begin
      if (radio_rst)
         o_tx <= '0;
      else
         o_tx <= i_run_tx ? i_tx_sample : i_codec_idle;
   end

   // Digital loopback takes the registered TX word
   assign rx_word = i_loopback ? o_tx : i_rx;

   always_ff @(posedge radio_clk) begin
      if (i_run_rx)
         o_rx_sample <= rx_word;
   end

   always_ff @(posedge radio_clk) begin
      if (radio_rst)
         o_rx_push <= 1'b0;
      else
         o_rx_push <= i_run_rx;
   end

endmodule

/* hw/rx_sample_fifo.sv */
`include "radio_settings.svh"

module rx_sample_fifo #(
   parameter int ADDR_WIDTH = `SAMPLE_FIFO_SIZE
) (
   input  logic                  radio_clk,
   input  logic                  radio_rst,
   input  logic                  i_push,
   input  radio_pkg::sample_t    i_data,
   input  logic                  i_pop,
   output radio_pkg::sample_t    o_data,
   output logic                  o_not_empty,
   output logic [ADDR_WIDTH:0]   o_count,
   output logic                  o_overflow
);
   import radio_pkg::*;

   localparam int DEPTH = 1 << ADDR_WIDTH;

   sample_t               mem [DEPTH];
   logic [ADDR_WIDTH-1:0] wr_ptr;
   logic [ADDR_WIDTH-1:0] rd_ptr;
   logic                  full;
   logic                  do_push;
   logic                  do_pop;

   assign full        = (o_count == (ADDR_WIDTH+1)'(DEPTH));
   assign o_not_empty = (o_count != '0);
   assign do_push     = i_push && !full;
   assign do_pop      = i_pop && o_not_empty;

   // First word falls through
   assign o_data = mem[rd_ptr];

   always_ff @(posedge radio_clk) begin
      if (do_push)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         o_count    <= '0;
         o_overflow <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   o_count <= o_count + 1'b1;
            2'b01:   o_count <= o_count - 1'b1;
            default: ;
         endcase
         // Word lost on a full FIFO
         o_overflow <= i_push && full;
      end
   end

endmodule

/* hw/rx_framer.sv */
`include "radio_settings.svh"

module rx_framer (
   input  logic                       radio_clk,
   input  logic                       radio_rst,
   input  radio_pkg::sample_t         i_fifo_data,
   input  logic [`SAMPLE_FIFO_SIZE:0] i_fifo_count,
   input  radio_pkg::pkt_len_t        i_pkt_len,
   input  radio_pkg::set_data_t       i_sid,
   input  logic                       i_rx_tready,
   output logic                       o_pop,
   output radio_pkg::chdr_word_t      o_rx_tdata,
   output logic                       o_rx_tlast,
   output logic                       o_rx_tvalid,
   output radio_pkg::framer_state_t   o_state
);
   import radio_pkg::*;

   framer_state_t state;
   pkt_len_t      len_r;
   pkt_len_t      beat_cnt;
   set_data_t     sid_r;
   seqnum_t       seqnum;
   sample_t       first_sample;
   logic          have_first;
   logic          out_free;
   logic          pkt_ready;
   logic          take_first;
   logic          emit_beat;
   logic          last_beat;

   // Output register empty or draining this cycle
   assign out_free  = !o_rx_tvalid || i_rx_tready;
   assign pkt_ready = (i_pkt_len != '0) && (i_fifo_count >= {i_pkt_len, 1'b0});

   // Earlier sample of a pair is popped with the header or on its own
   assign take_first = ((state == HEADER) && out_free) || ((state == PAYLOAD) && !have_first);
   assign emit_beat  = (state == PAYLOAD) && have_first && out_free;
   assign last_beat  = (beat_cnt == len_r - 8'd1);
   assign o_pop      = take_first || emit_beat;
   assign o_state    = state;

   always_ff @(posedge radio_clk) begin
      if ((state == IDLE) && pkt_ready) begin
         len_r <= i_pkt_len;
         sid_r <= i_sid;
      end
      if (take_first)
         first_sample <= i_fifo_data;
      if ((state == HEADER) && out_free)
         o_rx_tdata <= {seqnum, 7'd0, len_r, 1'b0, sid_r};
      else if (emit_beat)
         o_rx_tdata <= {first_sample, i_fifo_data};
   end

   ////////////////////////////////////////////////////////////////////////////
   // Packet FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         state       <= IDLE;
         o_rx_tvalid <= 1'b0;
         o_rx_tlast  <= 1'b0;
         have_first  <= 1'b0;
         beat_cnt    <= '0;
         seqnum      <= '0;
      end else begin
         if (o_rx_tvalid && i_rx_tready)
            o_rx_tvalid <= 1'b0;
         if (take_first)
            have_first <= 1'b1;
         else if (emit_beat)
            have_first <= 1'b0;
         case (state)
            IDLE: begin
               if (pkt_ready) begin
                  beat_cnt <= '0;
                  state    <= HEADER;
               end
            end
            HEADER: begin
               if (out_free) begin
                  o_rx_tvalid <= 1'b1;
                  o_rx_tlast  <= 1'b0;
                  state       <= PAYLOAD;
               end
            end
            PAYLOAD: begin
               if (emit_beat) begin
                  o_rx_tvalid <= 1'b1;
                  o_rx_tlast  <= last_beat;
                  beat_cnt    <= beat_cnt + 8'd1;
                  if (last_beat) begin
                     seqnum <= seqnum + 16'd1;
                     state  <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* hw/radio_core.sv */
`include "radio_settings.svh"

module radio_core (
   input  logic                  radio_clk,
   input  logic                  radio_rst,
   input  logic                  i_set_stb,
   input  radio_pkg::set_addr_t  i_set_addr,
   input  radio_pkg::set_data_t  i_set_data,
   input  radio_pkg::sample_t    i_rx,
   input  radio_pkg::sample_t    i_tx_sample,
   input  logic                  i_run_tx,
   input  logic                  i_run_rx,
   input  logic                  i_pps,
   input  logic                  i_rx_tready,
   output radio_pkg::sample_t    o_tx,
   output radio_pkg::rb_data_t   o_rb_data,
   output radio_pkg::chdr_word_t o_rx_tdata,
   output logic                  o_rx_tlast,
   output logic                  o_rx_tvalid
);
   import radio_pkg::*;

   vita_time_t                 vita_time;
   vita_time_t                 time_lastpps;
   logic                       loopback;
   sample_t                    codec_idle;
   pkt_len_t                   rx_pkt_len;
   set_data_t                  rx_sid;
   sample_t                    rx_sample;
   logic                       rx_push;
   sample_t                    fifo_data;
   logic [`SAMPLE_FIFO_SIZE:0] fifo_count;
   logic                       overflow;
   logic                       framer_pop;
   framer_state_t              framer_state;

   ////////////////////////////////////////////////////////////////////////////
   // Time and settings
   ////////////////////////////////////////////////////////////////////////////

   radio_timekeeper u_timekeeper (
      .radio_clk      (radio_clk),
      .radio_rst      (radio_rst),
      .i_set_stb      (i_set_stb),
      .i_set_addr     (i_set_addr),
      .i_set_data     (i_set_data),
      .i_pps          (i_pps),
      .o_vita_time    (vita_time),
      .o_time_lastpps (time_lastpps)
   );

   radio_settings_regs u_settings_regs (
      .radio_clk      (radio_clk),
      .radio_rst      (radio_rst),
      .i_set_stb      (i_set_stb),
      .i_set_addr     (i_set_addr),
      .i_set_data     (i_set_data),
      .i_vita_time    (vita_time),
      .i_time_lastpps (time_lastpps),
      .i_tx           (o_tx),
      .i_rx           (i_rx),
      .i_overflow     (overflow),
      .i_framer_state (framer_state),
      .o_loopback     (loopback),
      .o_codec_idle   (codec_idle),
      .o_rx_pkt_len   (rx_pkt_len),
      .o_rx_sid       (rx_sid),
      .o_rb_data      (o_rb_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Sample path
   ////////////////////////////////////////////////////////////////////////////

   radio_frontend u_frontend (
      .radio_clk    (radio_clk),
      .radio_rst    (radio_rst),
      .i_loopback   (loopback),
      .i_codec_idle (codec_idle),
      .i_tx_sample  (i_tx_sample),
      .i_run_tx     (i_run_tx),
      .i_rx         (i_rx),
      .i_run_rx     (i_run_rx),
      .o_tx         (o_tx),
      .o_rx_sample  (rx_sample),
      .o_rx_push    (rx_push)
   );

   rx_sample_fifo #(
      .ADDR_WIDTH (`SAMPLE_FIFO_SIZE)
   ) u_sample_fifo (
      .radio_clk   (radio_clk),
      .radio_rst   (radio_rst),
      .i_push      (rx_push),
      .i_data      (rx_sample),
      .i_pop       (framer_pop),
      .o_data      (fifo_data),
      .o_not_empty (),
      .o_count     (fifo_count),
      .o_overflow  (overflow)
   );

   rx_framer u_framer (
      .radio_clk    (radio_clk),
      .radio_rst    (radio_rst),
      .i_fifo_data  (fifo_data),
      .i_fifo_count (fifo_count),
      .i_pkt_len    (rx_pkt_len),
      .i_sid        (rx_sid),
      .i_rx_tready  (i_rx_tready),
      .o_pop        (framer_pop),
      .o_rx_tdata   (o_rx_tdata),
      .o_rx_tlast   (o_rx_tlast),
      .o_rx_tvalid  (o_rx_tvalid),
      .o_state      (framer_state)
   );

endmodule

/* tb/tb_radio_core.sv */
`include "radio_settings.svh"

module tb_radio_core;
   timeunit 1ns;
   timeprecision 100ps;

   import radio_pkg::*;

   localparam int        TIMEOUT_CYCLES = 3000;
   localparam int        PKT_LEN        = 3;
   localparam int        NUM_PKTS       = 2;
   localparam int        NUM_SAMPLES    = 2 * PKT_LEN * NUM_PKTS;
   localparam set_data_t STREAM_ID      = 32'hC0DE_0042;

   logic       radio_clk;
   logic       radio_rst;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   sample_t    rx;
   sample_t    tx_sample;
   logic       run_tx;
   logic       run_rx;
   logic       pps;
   logic       rx_tready;
   sample_t    tx;
   rb_data_t   rb_data;
   chdr_word_t rx_tdata;
   logic       rx_tlast;
   logic       rx_tvalid;

   integer     seed;
   int         cycle_cnt;
   int         check_count;
   int         error_count;
   sample_t    exp_samples[$];
   chdr_word_t beat_data[$];
   logic       beat_last[$];

   radio_core DUT (
      .radio_clk   (radio_clk),
      .radio_rst   (radio_rst),
      .i_set_stb   (set_stb),
      .i_set_addr  (set_addr),
      .i_set_data  (set_data),
      .i_rx        (rx),
      .i_tx_sample (tx_sample),
      .i_run_tx    (run_tx),
      .i_run_rx    (run_rx),
      .i_pps       (pps),
      .i_rx_tready (rx_tready),
      .o_tx        (tx),
      .o_rb_data   (rb_data),
      .o_rx_tdata  (rx_tdata),
      .o_rx_tlast  (rx_tlast),
      .o_rx_tvalid (rx_tvalid)
   );

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   // Cycle counter and run limit
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge radio_clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   // Beats accepted on the RX stream and sampled mid-cycle
   always @(negedge radio_clk) begin
      if (!radio_rst && rx_tvalid && rx_tready) begin
         beat_data.push_back(rx_tdata);
         beat_last.push_back(rx_tlast);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helper tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge radio_clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      assert (actual === expected)
      else begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // Register shows the value one cycle after the strobe
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      next_cycle();
      set_stb  = 1'b0;
   endtask

   task automatic check_packets();
      chdr_word_t header;
      chdr_word_t payload;
      int         beat;
      int         idx;
      beat = 0;
      for (int p = 0; p < NUM_PKTS; p++) begin
         header = {seqnum_t'(p), 16'(2 * PKT_LEN), STREAM_ID};
         check_value("rx header", header, beat_data[beat]);
         check_value("rx header last", 1'b0, beat_last[beat]);
         beat++;
         for (int j = 0; j < PKT_LEN; j++) begin
            idx     = 2 * (p * PKT_LEN + j);
            payload = {exp_samples[idx], exp_samples[idx + 1]};
            check_value("rx payload", payload, beat_data[beat]);
            check_value("rx payload last", (j == PKT_LEN - 1), beat_last[beat]);
            beat++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rb_data_t   load_now;
      rb_data_t   load_pps;
      rb_data_t   exp_lastpps;
      chdr_word_t held_data;
      logic       seen_valid;
      int         load_cycle;
      seed        = 76846;
      check_count = 0;
      error_count = 0;
      radio_rst   = 1'b1;
      set_stb     = 1'b0;
      set_addr    = '0;
      set_data    = '0;
      rx          = '0;
      tx_sample   = '0;
      run_tx      = 1'b0;
      run_rx      = 1'b0;
      pps         = 1'b0;
      rx_tready   = 1'b1;
      repeat (16) @(posedge radio_clk);
      #2;
      radio_rst = 1'b0;
      check_value("reset tx", '0, tx);
      check_value("reset tvalid", 1'b0, rx_tvalid);

      // Test register and unused selects
      write_setting(`SR_TEST, 32'h5A3C_96E1);
      write_setting(`SR_READBACK, 32'd0);
      check_value("readback test reg", 64'h0000_0000_5A3C_96E1, rb_data);
      for (int sel = 5; sel < 8; sel++) begin
         write_setting(`SR_READBACK, sel);
         check_value("readback unused", '0, rb_data);
      end

      // Immediate time load
      load_now = 64'h0000_0012_3456_7000;
      write_setting(`SR_READBACK, 32'd1);
      write_setting(`SR_TIME, load_now[63:32]);
      write_setting(`SR_TIME + 8'd1, load_now[31:0]);
      write_setting(`SR_TIME + 8'd2, 32'd1);
      load_cycle = cycle_cnt;
      check_value("time load now", load_now, rb_data);
      repeat (5) next_cycle();
      check_value("time count", load_now + 64'(cycle_cnt - load_cycle), rb_data);

      // Armed load taken on the PPS edge
      load_pps = 64'h0000_00AB_0000_0100;
      write_setting(`SR_TIME, load_pps[63:32]);
      write_setting(`SR_TIME + 8'd1, load_pps[31:0]);
      write_setting(`SR_TIME + 8'd2, 32'd0);
      pps = 1'b1;
      next_cycle();
      exp_lastpps = load_now + 64'(cycle_cnt - load_cycle);
      pps = 1'b0;
      next_cycle();
      check_value("time pps load", load_pps, rb_data);
      next_cycle();
      check_value("time after pps", load_pps + 64'd1, rb_data);
      write_setting(`SR_READBACK, 32'd2);
      check_value("time last pps", exp_lastpps, rb_data);

      // TX idle word and then live samples
      write_setting(`SR_CODEC_IDLE, 32'h7FFF_8001);
      next_cycle();
      check_value("tx idle", 32'h7FFF_8001, tx);
      run_tx    = 1'b1;
      tx_sample = 32'h1234_ABCD;
      next_cycle();
      check_value("tx running", 32'h1234_ABCD, tx);

      // TX and RX words side by side
      rx = 32'h0BAD_F00D;
      write_setting(`SR_READBACK, 32'd3);
      check_value("readback tx rx", 64'h1234_ABCD_0BAD_F00D, rb_data);

      // Loopback packets with RX one cycle behind TX
      write_setting(`SR_LOOPBACK, 32'd1);
      write_setting(`SR_RX_CTRL, PKT_LEN);
      write_setting(`SR_RX_CTRL + 8'd1, STREAM_ID);
      for (int i = 0; i < NUM_SAMPLES + 2; i++) begin
         tx_sample = $random(seed);
         if (i < NUM_SAMPLES)
            exp_samples.push_back(tx_sample);
         run_rx = (i >= 1) && (i <= NUM_SAMPLES);
         next_cycle();
      end
      while (beat_data.size() < NUM_PKTS * (PKT_LEN + 1))
         next_cycle();
      check_packets();

      // Back-pressure until the FIFO overflows
      rx_tready  = 1'b0;
      run_rx     = 1'b1;
      seen_valid = 1'b0;
      held_data  = '0;
      for (int i = 0; i < 50; i++) begin
         tx_sample = $random(seed);
         next_cycle();
         if (seen_valid) begin
            check_value("stall valid", 1'b1, rx_tvalid);
            check_value("stall data", held_data, rx_tdata);
         end else if (rx_tvalid) begin
            seen_valid = 1'b1;
            held_data  = rx_tdata;
         end
      end
      check_value("stall valid seen", 1'b1, seen_valid);
      run_rx = 1'b0;
      run_tx = 1'b0;
      repeat (3) next_cycle();
      write_setting(`SR_READBACK, 32'd4);
      check_value("overflow set", 64'h6, rb_data);
      write_setting(`SR_RX_CTRL + 8'd2, 32'd0);
      check_value("overflow cleared", 64'h2, rb_data);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* flist.f */
+incdir+hw
hw/radio_pkg.sv
hw/radio_timekeeper.sv
hw/radio_settings_regs.sv
hw/radio_frontend.sv
hw/rx_sample_fifo.sv
hw/rx_framer.sv
hw/radio_core.sv
tb/tb_radio_core.sv
